//--- verilog/core_pkg.sv
`default_nettype none

package core_pkg;

    // ********************
    // widths
    // ********************
    localparam int xlen       = 64;
    localparam int reg_addr_w = 5;
    localparam int num_regs   = 32;
    localparam int shamt_w    = 6;
    localparam int alu_sel_w  = 4;

    typedef logic [xlen-1:0]       xlen_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;
    typedef logic [alu_sel_w-1:0]  alu_sel_t;

    // ********************
    // encodings
    // ********************
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;

    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // sub and sra carry this in funct7
    localparam logic [6:0] funct7_alt = 7'b0100000;

    // alu operation codes
    localparam alu_sel_t alu_add  = 4'd0;
    localparam alu_sel_t alu_sub  = 4'd1;
    localparam alu_sel_t alu_and  = 4'd2;
    localparam alu_sel_t alu_or   = 4'd3;
    localparam alu_sel_t alu_xor  = 4'd4;
    localparam alu_sel_t alu_sll  = 4'd5;
    localparam alu_sel_t alu_srl  = 4'd6;
    localparam alu_sel_t alu_sra  = 4'd7;
    localparam alu_sel_t alu_slt  = 4'd8;
    localparam alu_sel_t alu_sltu = 4'd9;

    // one instruction word, R-type and I-type views
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            reg_addr_t  rs2;
            reg_addr_t  rs1;
            logic [2:0] funct3;
            reg_addr_t  rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm12;
            reg_addr_t   rs1;
            logic [2:0]  funct3;
            reg_addr_t   rd;
            logic [6:0]  opcode;
        } i;
    } inst_t;

endpackage

`default_nettype wire

//--- verilog/ex_bus_if.sv
`timescale 1ns/10ps
`default_nettype none

// decoded instruction, decode to execute
interface ex_bus_if import core_pkg::*; ();

    logic      valid;
    reg_addr_t rd;
    alu_sel_t  alu_sel;
    xlen_t     op1;
    xlen_t     op2;

    modport src (output valid, output rd, output alu_sel, output op1, output op2);

    modport dst (input valid, input rd, input alu_sel, input op1, input op2);

endinterface

`default_nettype wire

//--- verilog/reg_read_if.sv
`timescale 1ns/10ps
`default_nettype none

interface reg_read_if import core_pkg::*; ();

    reg_addr_t raddr1;
    reg_addr_t raddr2;
    xlen_t     rdata1;
    xlen_t     rdata2;

    // decode side
    modport req (output raddr1, output raddr2, input rdata1, input rdata2);
    // register file side
    modport rsp (input raddr1, input raddr2, output rdata1, output rdata2);

endinterface

`default_nettype wire

//--- verilog/inst_decode.sv
`timescale 1ns/10ps
`default_nettype none

module inst_decode import core_pkg::*; (
    input  logic    inst_valid_i,
    input  inst_t   inst_i,
    reg_read_if.req rd_port,
    ex_bus_if.src   ex_bus
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [11:0] imm12;
    xlen_t       imm_sext;
    alu_sel_t    sel;
    logic        use_imm;
    logic        supported;

    // ********************
    // field extraction
    // ********************
    assign opcode   = inst_i.r.opcode;
    assign funct3   = inst_i.r.funct3;
    assign funct7   = inst_i.r.funct7;
    assign imm12    = inst_i.i.imm12;
    assign imm_sext = {{(xlen - 12){imm12[11]}}, imm12};

    assign rd_port.raddr1 = inst_i.r.rs1;
    assign rd_port.raddr2 = inst_i.r.rs2;

    // ********************
    // alu select
    // ********************
    always_comb begin
        sel       = alu_add;
        use_imm   = 1'b0;
        supported = 1'b0;
        case (opcode)
            opc_op: begin
                case (funct3)
                    f3_add_sub: sel = (funct7 == funct7_alt) ? alu_sub : alu_add;
                    f3_sll:     sel = alu_sll;
                    f3_slt:     sel = alu_slt;
                    f3_sltu:    sel = alu_sltu;
                    f3_xor:     sel = alu_xor;
                    f3_srl_sra: sel = (funct7 == funct7_alt) ? alu_sra : alu_srl;
                    f3_or:      sel = alu_or;
                    default:    sel = alu_and;
                endcase
                // alternate funct7 only for sub and sra
                if (funct7 == funct7_alt) begin
                    supported = (funct3 == f3_add_sub) || (funct3 == f3_srl_sra);
                end else begin
                    supported = (funct7 == 7'd0);
                end
            end
            opc_op_imm: begin
                use_imm   = 1'b1;
                supported = 1'b1;
                case (funct3)
                    f3_add_sub: sel = alu_add;
                    f3_sll: begin
                        sel       = alu_sll;
                        supported = (imm12[11:6] == 6'd0);
                    end
                    f3_slt:     sel = alu_slt;
                    f3_sltu:    sel = alu_sltu;
                    f3_xor:     sel = alu_xor;
                    f3_srl_sra: begin
                        // upper six bits select srli or srai
                        sel = (imm12[11:6] == funct7_alt[6:1]) ? alu_sra : alu_srl;
                        supported = (imm12[11:6] == 6'd0) || (imm12[11:6] == funct7_alt[6:1]);
                    end
                    f3_or:      sel = alu_or;
                    default:    sel = alu_and;
                endcase
            end
            default: begin
                supported = 1'b0;
            end
        endcase
    end

    // ********************
    // bus to execute
    // ********************
    assign ex_bus.valid   = inst_valid_i && supported;
    assign ex_bus.rd      = inst_i.r.rd;
    assign ex_bus.alu_sel = sel;
    assign ex_bus.op1     = rd_port.rdata1;
    assign ex_bus.op2     = use_imm ? imm_sext : rd_port.rdata2;

endmodule

`default_nettype wire

//--- verilog/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file import core_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    reg_read_if.rsp   rd_port,
    input  logic      wen_i,
    input  reg_addr_t waddr_i,
    input  xlen_t     wdata_i
);

    // x0 has no storage
    xlen_t regs [1:num_regs-1];

    // read with write-through from the port being written this cycle
    function automatic xlen_t read_port(input reg_addr_t addr);
        xlen_t data;
        if (addr == '0) begin
            data = '0;
        end else if (wen_i && (waddr_i == addr)) begin
            data = wdata_i;
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    always_ff @(posedge clk) begin
        if (rst_n) begin
            for (int i = 1; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wen_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    always_comb begin
        rd_port.rdata1 = read_port(rd_port.raddr1);
        rd_port.rdata2 = read_port(rd_port.raddr2);
    end

endmodule

`default_nettype wire

//--- verilog/alu_exec.sv
`timescale 1ns/10ps
`default_nettype none

module alu_exec import core_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    ex_bus_if.dst     ex_bus,
    output logic      wen_o,
    output reg_addr_t waddr_o,
    output xlen_t     wdata_o,
    output logic      wb_valid_o,
    output reg_addr_t wb_rd_o,
    output xlen_t     wb_data_o
);

    logic               valid_q;
    reg_addr_t          rd_q;
    alu_sel_t           sel_q;
    xlen_t              op1_q;
    xlen_t              op2_q;
    logic [shamt_w-1:0] shamt;
    xlen_t              result;

    // ********************
    // ID/EX register
    // ********************
    always_ff @(posedge clk) begin
        if (rst_n) begin
            valid_q <= 1'b0;
            rd_q    <= '0;
            sel_q   <= alu_add;
            op1_q   <= '0;
            op2_q   <= '0;
        end else begin
            valid_q <= ex_bus.valid;
            rd_q    <= ex_bus.rd;
            sel_q   <= ex_bus.alu_sel;
            op1_q   <= ex_bus.op1;
            op2_q   <= ex_bus.op2;
        end
    end

    // ********************
    // ALU
    // ********************
    assign shamt = op2_q[shamt_w-1:0];

    always_comb begin
        case (sel_q)
            alu_add:  result = op1_q + op2_q;
            alu_sub:  result = op1_q - op2_q;
            alu_and:  result = op1_q & op2_q;
            alu_or:   result = op1_q | op2_q;
            alu_xor:  result = op1_q ^ op2_q;
            alu_sll:  result = op1_q << shamt;
            alu_srl:  result = op1_q >> shamt;
            alu_sra:  result = $signed(op1_q) >>> shamt;
            alu_slt:  result = {{(xlen - 1){1'b0}}, $signed(op1_q) < $signed(op2_q)};
            alu_sltu: result = {{(xlen - 1){1'b0}}, op1_q < op2_q};
            default:  result = '0;
        endcase
    end

    // write port, x0 never written
    assign wen_o   = valid_q && (rd_q != '0);
    assign waddr_o = rd_q;
    assign wdata_o = result;

    // writeback report, x0 included
    assign wb_valid_o = valid_q;
    assign wb_rd_o    = rd_q;
    assign wb_data_o  = result;

endmodule

`default_nettype wire

//--- verilog/core_top.sv
`timescale 1ns/10ps
`default_nettype none

module core_top import core_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        inst_valid_i,
    input  logic [31:0] inst_i,
    output logic        wb_valid_o,
    output reg_addr_t   wb_rd_o,
    output xlen_t       wb_data_o
);

    // register write port
    logic      wen;
    reg_addr_t waddr;
    xlen_t     wdata;

    ex_bus_if   ex_bus ();
    reg_read_if rd_port ();

    inst_decode u_inst_decode (
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i      ),
        .rd_port      (rd_port     ),
        .ex_bus       (ex_bus      )
    );

    reg_file u_reg_file (
        .clk     (clk    ),
        .rst_n   (rst_n  ),
        .rd_port (rd_port),
        .wen_i   (wen    ),
        .waddr_i (waddr  ),
        .wdata_i (wdata  )
    );

    alu_exec u_alu_exec (
        .clk        (clk       ),
        .rst_n      (rst_n     ),
        .ex_bus     (ex_bus    ),
        .wen_o      (wen       ),
        .waddr_o    (waddr     ),
        .wdata_o    (wdata     ),
        .wb_valid_o (wb_valid_o),
        .wb_rd_o    (wb_rd_o   ),
        .wb_data_o  (wb_data_o )
    );

endmodule

`default_nettype wire

//--- sim/core_chk.sv
`timescale 1ns/10ps
`default_nettype none

module core_chk import core_pkg::*; (
    input logic      clk,
    input logic      rst_n,
    input logic      inst_valid_i,
    input logic      wb_valid_i,
    input reg_addr_t wb_rd_i,
    input reg_addr_t raddr1_i,
    input xlen_t     rdata1_i
);

    // failed assertions so far
    int fail_count = 0;

    a_reset_idle: assert property (@(posedge clk) rst_n |=> !wb_valid_i)
        else begin
            fail_count++;
            $error("writeback valid while in reset");
        end

    // one cycle of latency from strobe to writeback
    a_wb_after_strobe: assert property (@(posedge clk) disable iff (rst_n)
        wb_valid_i |-> $past(inst_valid_i))
        else begin
            fail_count++;
            $error("writeback without a strobe one cycle earlier");
        end

    a_x0_stays_zero: assert property (@(posedge clk) disable iff (rst_n)
        (wb_valid_i && wb_rd_i == '0) |=> (raddr1_i != '0 || rdata1_i == '0))
        else begin
            fail_count++;
            $error("x0 read nonzero after a write to x0");
        end

endmodule

bind core_top core_chk chk0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .inst_valid_i (inst_valid_i),
    .wb_valid_i   (wb_valid_o),
    .wb_rd_i      (wb_rd_o),
    .raddr1_i     (rd_port.raddr1),
    .rdata1_i     (rd_port.rdata1)
);

`default_nettype wire

//--- sim/tb_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_core import core_pkg::*; ();

    logic        clk;
    logic        rst_n;
    logic        inst_valid_i;
    logic [31:0] inst_i;
    logic        wb_valid_o;
    reg_addr_t   wb_rd_o;
    xlen_t       wb_data_o;

    // architectural state as the testbench expects it
    xlen_t       model_regs [0:31];
    logic [31:0] rng_state;

    // stimulus table
    string       tbl_name [$];
    inst_t       tbl_inst [$];
    reg_addr_t   tbl_rd [$];
    xlen_t       tbl_data [$];

    core_top dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .wb_valid_o   (wb_valid_o),
        .wb_rd_o      (wb_rd_o),
        .wb_data_o    (wb_data_o)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // RV64 result of one supported instruction
    function automatic xlen_t model_result(input inst_t w);
        xlen_t a;
        xlen_t b;
        logic  is_r;
        a    = model_regs[w.r.rs1];
        is_r = (w.r.opcode == opc_op);
        b    = is_r ? model_regs[w.r.rs2] : {{52{w.i.imm12[11]}}, w.i.imm12};
        case (w.r.funct3)
            3'd0:    return (is_r && w.r.funct7[5]) ? a - b : a + b;
            3'd1:    return a << b[5:0];
            3'd2:    return xlen_t'($signed(a) < $signed(b));
            3'd3:    return xlen_t'(a < b);
            3'd4:    return a ^ b;
            3'd5:    return w.r.funct7[5] ? xlen_t'($signed(a) >>> b[5:0]) : a >> b[5:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // ********************
    // checks
    // ********************
    task automatic stop_on_error();
        $display(">>> FAIL");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_rd(input string name, input reg_addr_t exp, input reg_addr_t act);
        if (act !== exp) begin
            $display("Fail %s: rd expected %0d actual %0d", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_data(input string name, input xlen_t exp, input xlen_t act);
        if (act !== exp) begin
            $display("Fail %s: data expected %h actual %h", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_valid(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Fail %s: wb_valid expected %b actual %b", name, exp, act);
            stop_on_error();
        end
    endtask

    // ********************
    // stimulus
    // ********************
    // called at a falling edge, returns at the falling edge of the writeback
    task automatic run_inst(input string name, input inst_t w, input reg_addr_t exp_rd,
                            input xlen_t exp_data);
        int cycles;
        inst_i       = w;
        inst_valid_i = 1'b1;
        cycles       = 0;
        do begin
            @(negedge clk);
            inst_valid_i = 1'b0;
            cycles++;
            if (cycles > 16) begin
                $display("No writeback for %s after %0d cycles", name, cycles);
                stop_on_error();
            end
        end while (!wb_valid_o);
        check_rd(name, exp_rd, wb_rd_o);
        check_data(name, exp_data, wb_data_o);
        if (exp_rd != '0)
            model_regs[exp_rd] = exp_data;
    endtask

    task automatic run_unsupported(input string name, input logic [31:0] w);
        inst_i       = w;
        inst_valid_i = 1'b1;
        @(negedge clk);
        inst_valid_i = 1'b0;
        check_valid(name, 1'b0, wb_valid_o);
    endtask

    task automatic add_entry(input string name, input inst_t w, input reg_addr_t rd,
                             input xlen_t data);
        tbl_name.push_back(name);
        tbl_inst.push_back(w);
        tbl_rd.push_back(rd);
        tbl_data.push_back(data);
    endtask

    task automatic build_table();
        // immediates, sign extended
        add_entry("addi_pos", {12'd100, 5'd0, 3'd0, 5'd1, opc_op_imm}, 5'd1, 64'd100);
        add_entry("addi_neg", {12'hffb, 5'd0, 3'd0, 5'd2, opc_op_imm}, 5'd2, '1 - 64'd4);
        add_entry("andi", {12'h0f0, 5'd2, 3'd7, 5'd3, opc_op_imm}, 5'd3, 64'hf0);
        add_entry("ori_neg", {12'hf00, 5'd1, 3'd6, 5'd4, opc_op_imm}, 5'd4, 64'hffff_ffff_ffff_ff64);
        add_entry("xori_neg", {12'hfff, 5'd1, 3'd4, 5'd5, opc_op_imm}, 5'd5, 64'hffff_ffff_ffff_ff9b);
        add_entry("slti", {12'hffc, 5'd2, 3'd2, 5'd6, opc_op_imm}, 5'd6, 64'd1);
        add_entry("sltiu", {12'hfff, 5'd1, 3'd3, 5'd7, opc_op_imm}, 5'd7, 64'd1);
        // register ops on the values above
        add_entry("add", {7'h00, 5'd2, 5'd1, 3'd0, 5'd9, opc_op}, 5'd9, 64'd95);
        add_entry("sub", {7'h20, 5'd2, 5'd1, 3'd0, 5'd10, opc_op}, 5'd10, 64'd105);
        add_entry("and", {7'h00, 5'd5, 5'd4, 3'd7, 5'd11, opc_op}, 5'd11, 64'hffff_ffff_ffff_ff00);
        add_entry("or", {7'h00, 5'd1, 5'd3, 3'd6, 5'd12, opc_op}, 5'd12, 64'hf4);
        add_entry("xor", {7'h00, 5'd5, 5'd4, 3'd4, 5'd13, opc_op}, 5'd13, 64'hff);
        add_entry("slt", {7'h00, 5'd1, 5'd2, 3'd2, 5'd14, opc_op}, 5'd14, 64'd1);
        add_entry("sltu", {7'h00, 5'd1, 5'd2, 3'd3, 5'd15, opc_op}, 5'd15, 64'd0);
        // shifts
        add_entry("slli_63", {12'd63, 5'd6, 3'd1, 5'd16, opc_op_imm}, 5'd16, 64'h8000_0000_0000_0000);
        add_entry("srai_63", {12'h43f, 5'd16, 3'd5, 5'd17, opc_op_imm}, 5'd17, '1);
        add_entry("srli_63", {12'd63, 5'd16, 3'd5, 5'd18, opc_op_imm}, 5'd18, 64'd1);
        add_entry("slli_0", {12'd0, 5'd1, 3'd1, 5'd19, opc_op_imm}, 5'd19, 64'd100);
        add_entry("sll", {7'h00, 5'd6, 5'd1, 3'd1, 5'd20, opc_op}, 5'd20, 64'd200);
        add_entry("srl", {7'h00, 5'd6, 5'd2, 3'd5, 5'd21, opc_op}, 5'd21, 64'h7fff_ffff_ffff_fffd);
        add_entry("sra", {7'h20, 5'd6, 5'd2, 3'd5, 5'd22, opc_op}, 5'd22, 64'hffff_ffff_ffff_fffd);
        // x12 holds f4, only the low six bits count
        add_entry("sll_wide", {7'h00, 5'd12, 5'd1, 3'd1, 5'd23, opc_op}, 5'd23, 64'h0640_0000_0000_0000);
        // back to back through the bypass
        add_entry("b2b_first", {12'd7, 5'd0, 3'd0, 5'd25, opc_op_imm}, 5'd25, 64'd7);
        add_entry("b2b_addi", {12'd3, 5'd25, 3'd0, 5'd25, opc_op_imm}, 5'd25, 64'd10);
        add_entry("b2b_add", {7'h00, 5'd25, 5'd25, 3'd0, 5'd26, opc_op}, 5'd26, 64'd20);
        // x0 writes are reported but not kept
        add_entry("x0_write", {12'd5, 5'd1, 3'd0, 5'd0, opc_op_imm}, 5'd0, 64'd105);
        add_entry("x0_read", {7'h00, 5'd1, 5'd0, 3'd0, 5'd27, opc_op}, 5'd27, 64'd100);
    endtask

    task automatic run_random(input int count);
        inst_t      w;
        logic [2:0] f3;
        logic [6:0] f7;
        for (int n = 0; n < count; n++) begin
            rng_state = xorshift(rng_state);
            f3 = rng_state[2:0];
            // alternate form only for sub and sra
            f7 = (rng_state[4] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
            if (rng_state[3]) begin
                w = {f7, rng_state[9:5], rng_state[14:10], f3, rng_state[19:15], opc_op};
            end else if (f3 == 3'd1 || f3 == 3'd5) begin
                w = {f7[6:1], rng_state[25:20], rng_state[14:10], f3, rng_state[19:15],
                     opc_op_imm};
            end else begin
                w = {rng_state[31:20], rng_state[14:10], f3, rng_state[19:15], opc_op_imm};
            end
            run_inst($sformatf("random_%0d", n), w, w.r.rd, model_result(w));
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b1;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        rng_state    = 32'h10c6f3bd;
        foreach (model_regs[i])
            model_regs[i] = '0;
        build_table();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b0;
        foreach (tbl_inst[i])
            run_inst(tbl_name[i], tbl_inst[i], tbl_rd[i], tbl_data[i]);
        // ld x1, 0(x0) and mul x3, x1, x2
        run_unsupported("load", 32'h0000_3083);
        run_unsupported("mul", {7'h01, 5'd2, 5'd1, 3'd0, 5'd3, opc_op});
        run_random(200);
        if (dut0.chk0.fail_count == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display("%0d assertion failures in core_chk", dut0.chk0.fail_count);
            stop_on_error();
        end
    end

endmodule

`default_nettype wire

//--- sim.f
verilog/core_pkg.sv
verilog/ex_bus_if.sv
verilog/reg_read_if.sv
verilog/inst_decode.sv
verilog/reg_file.sv
verilog/alu_exec.sv
verilog/core_top.sv
sim/core_chk.sv
sim/tb_core.sv
